// File: hw/blackjack_pkg.sv
// ----------------------------------------
// blackjack table shared definitions
// widths, card and score types, state and
// outcome encodings, table limits
// ----------------------------------------

package blackjack_pkg;

    // ----------------------------------------
    // value types
    // ----------------------------------------
    // one card, 1 to 10
    typedef logic [3:0] card_t;
    // hand total, hard or soft
    typedef logic [5:0] score_t;
    typedef logic [3:0] bet_t;
    // purse, saturates at 255
    typedef logic [7:0] coin_t;

    // ----------------------------------------
    // encodings
    // ----------------------------------------
    typedef enum logic [2:0] {
        st_betting = 3'd0,
        st_deal    = 3'd1,
        st_player  = 3'd2,
        st_dealer  = 3'd3,
        st_result  = 3'd4
    } game_state_t;

    typedef enum logic [2:0] {
        oc_none  = 3'd0,
        oc_lose  = 3'd1,
        oc_draw  = 3'd2,
        oc_win   = 3'd3,
        oc_win21 = 3'd4
    } outcome_t;

    // ----------------------------------------
    // table limits
    // ----------------------------------------
    localparam score_t blackjack_total    = 6'd21;
    localparam score_t dealer_stand_total = 6'd17;
    // ace upgrade, 1 counts as 11
    localparam score_t soft_ace_bonus     = 6'd10;
    // two player and two dealer cards per deal
    localparam int unsigned deal_cards    = 4;

endpackage

// File: hw/deck_lfsr.sv
// ----------------------------------------
// deck card source
// 16-bit galois lfsr, one step per draw,
// low nibble folded onto card values 1..10
// ----------------------------------------

`timescale 1ns/100ps

module deck_lfsr #(
    parameter logic [15:0] deck_seed = 16'hace1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 draw,
    output blackjack_pkg::card_t card
);

    // taps 16,14,13,11
    localparam logic [15:0] lfsr_mask = 16'hb400;
    // 0 and 11..15 count as a face card
    localparam blackjack_pkg::card_t face_value = 4'd10;

    logic [15:0]          lfsr;
    blackjack_pkg::card_t nibble;

    // ----------------------------------------
    // lfsr state
    // ----------------------------------------
    // seed reload only at reset, deck runs on across rounds
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= deck_seed;
        end else if (draw) begin
            // shift right, fold the mask in when bit 0 falls out
            if (lfsr[0]) begin
                lfsr <= (lfsr >> 1) ^ lfsr_mask;
            end else begin
                lfsr <= lfsr >> 1;
            end
        end
    end

    // ----------------------------------------
    // card mapping
    // ----------------------------------------
    // card taken is the one on offer before the step
    assign nibble = lfsr[3:0];
    assign card   = ((nibble >= 4'd1) && (nibble <= face_value)) ? nibble : face_value;

endmodule

// File: hw/bet_purse.sv
// ----------------------------------------
// bet register and purse
// validates and latches the bet, debits it
// at deal, credits the payout at settle
// ----------------------------------------

`timescale 1ns/100ps

module bet_purse #(
    parameter blackjack_pkg::coin_t initial_coin = 8'd30
) (
    input  logic                    clk,
    input  logic                    reset,
    input  blackjack_pkg::bet_t     bet,
    input  logic                    place_bet,
    input  logic                    pay,
    input  blackjack_pkg::outcome_t outcome,
    output logic                    bet_ok,
    output blackjack_pkg::coin_t    coin
);

    // bet held for the whole round
    blackjack_pkg::bet_t bet_q;
    // payout up to 4 x 15, one extra bit for the sum carry
    logic [8:0]          credit;
    logic [8:0]          coin_sum;

    // nonzero and covered by the purse
    assign bet_ok = (bet != '0) && (blackjack_pkg::coin_t'(bet) <= coin);

    // ----------------------------------------
    // payout
    // ----------------------------------------
    always_comb begin
        case (outcome)
            // 21 pays four times
            blackjack_pkg::oc_win21: credit = 9'(bet_q) << 2;
            blackjack_pkg::oc_win:   credit = 9'(bet_q) << 1;
            // stake returned
            blackjack_pkg::oc_draw:  credit = 9'(bet_q);
            default:                 credit = '0;
        endcase
    end

    assign coin_sum = 9'(coin) + credit;

    // ----------------------------------------
    // purse
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coin <= initial_coin;
        end else if (place_bet) begin
            // bet_ok guarantees no underflow
            coin <= coin - blackjack_pkg::coin_t'(bet);
        end else if (pay) begin
            // clamp at 255
            coin <= coin_sum[8] ? '1 : coin_sum[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (place_bet) begin
            bet_q <= bet;
        end
    end

endmodule

// File: hw/hand_score.sv
// ----------------------------------------
// hand total
// hard sum plus ace flag, shows the soft
// total when an ace can count as 11
// ----------------------------------------

`timescale 1ns/100ps

module hand_score (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  add,
    input  blackjack_pkg::card_t  card,
    output blackjack_pkg::score_t total
);

    blackjack_pkg::score_t hard_sum;
    logic                  ace_held;
    logic                  soft_ok;

    // ----------------------------------------
    // hard sum and ace flag
    // ----------------------------------------
    // bust stops drawing, so the hard sum stays below 32
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hard_sum <= '0;
            ace_held <= 1'b0;
        end else if (clear) begin
            // new round
            hard_sum <= '0;
            ace_held <= 1'b0;
        end else if (add) begin
            hard_sum <= hard_sum + blackjack_pkg::score_t'(card);
            if (card == 4'd1) begin
                ace_held <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // shown total
    // ----------------------------------------
    // only one ace can ever be upgraded
    assign soft_ok = ace_held &&
        ((hard_sum + blackjack_pkg::soft_ace_bonus) <= blackjack_pkg::blackjack_total);

    assign total = soft_ok ? (hard_sum + blackjack_pkg::soft_ace_bonus) : hard_sum;

endmodule

// File: hw/game_fsm.sv
// ----------------------------------------
// round sequencer
// betting, four-card deal, player turn,
// dealer draw to 17, result
// routes every drawn card to one hand
// ----------------------------------------

`timescale 1ns/100ps

module game_fsm (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  next,
    input  logic                  hit,
    input  logic                  stand,
    input  logic                  bet_ok,
    input  blackjack_pkg::score_t player_total,
    input  blackjack_pkg::score_t dealer_total,
    output logic                  draw,
    output logic                  player_add,
    output logic                  dealer_add,
    output logic                  hands_clear,
    output logic                  place_bet,
    output logic                  settle,
    output logic                  player_turn
);

    blackjack_pkg::game_state_t state;
    blackjack_pkg::game_state_t state_next;
    // card index within the deal
    logic [1:0]                 deal_cnt;
    logic                       deal_last;
    logic                       in_deal;
    logic                       take_bet;
    logic                       player_hit;
    logic                       dealer_hit;

    // ----------------------------------------
    // decode
    // ----------------------------------------
    assign in_deal   = (state == blackjack_pkg::st_deal);
    assign deal_last = (deal_cnt == 2'(blackjack_pkg::deal_cards - 1));
    assign take_bet  = (state == blackjack_pkg::st_betting) && next && bet_ok;

    // hit only taken below 21, stand wins a tie with hit
    assign player_hit = (state == blackjack_pkg::st_player) && hit && !stand &&
                        (player_total < blackjack_pkg::blackjack_total);

    // dealer keeps drawing under 17, soft totals included
    assign dealer_hit = (state == blackjack_pkg::st_dealer) &&
                        (dealer_total < blackjack_pkg::dealer_stand_total);

    // ----------------------------------------
    // next state
    // ----------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            blackjack_pkg::st_betting: begin
                if (take_bet) begin
                    state_next = blackjack_pkg::st_deal;
                end
            end
            blackjack_pkg::st_deal: begin
                if (deal_last) begin
                    state_next = blackjack_pkg::st_player;
                end
            end
            blackjack_pkg::st_player: begin
                // total here already holds the last hit
                if (player_total > blackjack_pkg::blackjack_total) begin
                    state_next = blackjack_pkg::st_result;
                end else if (player_total == blackjack_pkg::blackjack_total) begin
                    state_next = blackjack_pkg::st_dealer;
                end else if (stand) begin
                    state_next = blackjack_pkg::st_dealer;
                end
            end
            blackjack_pkg::st_dealer: begin
                if (!dealer_hit) begin
                    state_next = blackjack_pkg::st_result;
                end
            end
            blackjack_pkg::st_result: begin
                if (next) begin
                    state_next = blackjack_pkg::st_betting;
                end
            end
            default: begin
                state_next = blackjack_pkg::st_betting;
            end
        endcase
    end

    // ----------------------------------------
    // state, deal counter, settle strobe
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= blackjack_pkg::st_betting;
            deal_cnt <= '0;
            settle   <= 1'b0;
        end else begin
            state <= state_next;
            // wraps back to 0 on the last deal card
            deal_cnt <= in_deal ? deal_cnt + 2'd1 : 2'd0;
            // high for the entry cycle of result only
            settle <= (state_next == blackjack_pkg::st_result) &&
                      (state != blackjack_pkg::st_result);
        end
    end

    // ----------------------------------------
    // strobes
    // ----------------------------------------
    // deal order player, dealer, player, dealer
    assign draw        = in_deal || player_hit || dealer_hit;
    assign player_add  = (in_deal && !deal_cnt[0]) || player_hit;
    assign dealer_add  = (in_deal && deal_cnt[0]) || dealer_hit;
    // both hands and the purse move on the bet edge
    assign hands_clear = take_bet;
    assign place_bet   = take_bet;
    assign player_turn = (state == blackjack_pkg::st_player);

endmodule

// File: hw/hand_settle.sv
// ----------------------------------------
// round settlement
// compares the final totals, holds the
// outcome and the win, lose, draw levels
// ----------------------------------------

`timescale 1ns/100ps

module hand_settle (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    settle,
    input  logic                    next,
    input  blackjack_pkg::score_t   player_total,
    input  blackjack_pkg::score_t   dealer_total,
    output blackjack_pkg::outcome_t outcome,
    output logic                    pay,
    output logic                    win,
    output logic                    lose,
    output logic                    draw
);

    blackjack_pkg::outcome_t outcome_q;
    logic                    player_21;

    assign player_21 = (player_total == blackjack_pkg::blackjack_total);

    // ----------------------------------------
    // outcome rules, first match wins
    // ----------------------------------------
    always_comb begin
        if (player_total > blackjack_pkg::blackjack_total) begin
            // player bust beats everything
            outcome = blackjack_pkg::oc_lose;
        end else if (dealer_total > blackjack_pkg::blackjack_total) begin
            outcome = player_21 ? blackjack_pkg::oc_win21 : blackjack_pkg::oc_win;
        end else if (player_total > dealer_total) begin
            outcome = player_21 ? blackjack_pkg::oc_win21 : blackjack_pkg::oc_win;
        end else if (player_total < dealer_total) begin
            outcome = blackjack_pkg::oc_lose;
        end else begin
            outcome = blackjack_pkg::oc_draw;
        end
    end

    // purse credit lands on the same edge as the flags
    assign pay = settle;

    // ----------------------------------------
    // held outcome
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            outcome_q <= blackjack_pkg::oc_none;
        end else if (settle) begin
            outcome_q <= outcome;
        end else if (next) begin
            // back to betting
            outcome_q <= blackjack_pkg::oc_none;
        end
    end

    assign win  = (outcome_q == blackjack_pkg::oc_win) || (outcome_q == blackjack_pkg::oc_win21);
    assign lose = (outcome_q == blackjack_pkg::oc_lose);
    assign draw = (outcome_q == blackjack_pkg::oc_draw);

endmodule

// File: hw/blackjack_top.sv
// ----------------------------------------
// blackjack table controller
// one player, one purse, dealer draws to 17
// ----------------------------------------

`timescale 1ns/100ps

module blackjack_top #(
    parameter blackjack_pkg::coin_t initial_coin = 8'd30,
    parameter logic [15:0]          deck_seed    = 16'hace1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  next,
    input  logic                  hit,
    input  logic                  stand,
    input  blackjack_pkg::bet_t   bet,
    output blackjack_pkg::score_t player_score,
    output blackjack_pkg::score_t dealer_score,
    output blackjack_pkg::coin_t  coin,
    output logic                  player_turn,
    output logic                  win,
    output logic                  lose,
    output logic                  draw
);

    // ----------------------------------------
    // internal strobes and buses
    // ----------------------------------------
    blackjack_pkg::card_t    card;
    blackjack_pkg::outcome_t outcome;
    // deck step, not the draw flag
    logic                    card_draw;
    logic                    player_add;
    logic                    dealer_add;
    logic                    hands_clear;
    logic                    place_bet;
    logic                    bet_ok;
    logic                    settle;
    logic                    pay;

    // input side
    deck_lfsr #(.deck_seed(deck_seed)) i_deck_lfsr (
        .clk(clk), .reset(reset), .draw(card_draw), .card(card)
    );

    bet_purse #(.initial_coin(initial_coin)) i_bet_purse (
        .clk(clk), .reset(reset), .bet(bet), .place_bet(place_bet), .pay(pay),
        .outcome(outcome), .bet_ok(bet_ok), .coin(coin)
    );

    // processing
    hand_score i_player_hand (
        .clk(clk), .reset(reset), .clear(hands_clear), .add(player_add),
        .card(card), .total(player_score)
    );

    hand_score i_dealer_hand (
        .clk(clk), .reset(reset), .clear(hands_clear), .add(dealer_add),
        .card(card), .total(dealer_score)
    );

    game_fsm i_game_fsm (
        .clk(clk), .reset(reset), .next(next), .hit(hit), .stand(stand),
        .bet_ok(bet_ok), .player_total(player_score), .dealer_total(dealer_score),
        .draw(card_draw), .player_add(player_add), .dealer_add(dealer_add),
        .hands_clear(hands_clear), .place_bet(place_bet), .settle(settle),
        .player_turn(player_turn)
    );

    // output side
    hand_settle i_hand_settle (
        .clk(clk), .reset(reset), .settle(settle), .next(next),
        .player_total(player_score), .dealer_total(dealer_score),
        .outcome(outcome), .pay(pay), .win(win), .lose(lose), .draw(draw)
    );

endmodule

// File: dv/blackjack_chk.sv
// ----------------------------------------
// blackjack table assertions
// bound onto the top level, watches the
// outcome levels, player turn and purse
// ----------------------------------------

`timescale 1ns/100ps

module blackjack_chk (
    input logic                 clk,
    input logic                 reset,
    input logic                 player_turn,
    input logic                 win,
    input logic                 lose,
    input logic                 draw,
    input logic                 pay,
    input blackjack_pkg::coin_t coin
);

    // one outcome level at a time
    a_flags_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0({win, lose, draw})
    ) else $error("more than one of win, lose and draw is high");

    // flags only come up after the player turn is over
    a_turn_no_flag: assert property (
        @(posedge clk) disable iff (reset) player_turn |-> !(win || lose || draw)
    ) else $error("player_turn is high while an outcome flag is high");

    // credit clamps at 255 instead of wrapping past it
    a_purse_limit: assert property (
        @(posedge clk) disable iff (reset) pay |=> (coin >= $past(coin))
    ) else $error("purse went past 255 and wrapped on a payout");

endmodule

bind blackjack_top blackjack_chk i_blackjack_chk (
    .clk(clk), .reset(reset), .player_turn(player_turn), .win(win),
    .lose(lose), .draw(draw), .pay(pay), .coin(coin)
);

// File: dv/blackjack_tb.sv
// ----------------------------------------
// blackjack table testbench
// plays a table of rounds against a model
// of the deck, scoring, dealer and payout
// ----------------------------------------

`timescale 1ns/100ps

module blackjack_tb;

    localparam blackjack_pkg::coin_t start_coin = 8'd30;
    localparam logic [15:0]          start_seed = 16'hace1;
    localparam int table_rows      = 6;
    localparam int extra_rows      = 4;
    localparam int total_rows      = table_rows + extra_rows;
    localparam int cycles_per_row  = 200;
    localparam int flag_wait_limit = 40;

    // ----------------------------------------
    // stimulus table, bet / hits / refused bet first
    // ----------------------------------------
    localparam blackjack_pkg::bet_t fixed_bet [table_rows] =
        '{4'd3, 4'd1, 4'd2, 4'd4, 4'd2, 4'd1};
    localparam int fixed_hits [table_rows] = '{0, 1, 2, 3, 1, 5};
    localparam logic fixed_bad [table_rows] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};

    logic                  clk;
    logic                  reset;
    logic                  next;
    logic                  hit;
    logic                  stand;
    blackjack_pkg::bet_t   bet;
    blackjack_pkg::score_t player_score;
    blackjack_pkg::score_t dealer_score;
    blackjack_pkg::coin_t  coin;
    logic                  player_turn;
    logic                  win;
    logic                  lose;
    logic                  draw;

    // full table, fixed rows then lfsr rows
    blackjack_pkg::bet_t row_bet [total_rows];
    int                  row_hits [total_rows];
    logic                row_bad [total_rows];

    // reference model state
    logic [15:0]          model_deck;
    logic [31:0]          rand_state;
    blackjack_pkg::coin_t model_coin;
    int                   p_hard;
    logic                 p_ace;
    int                   d_hard;
    logic                 d_ace;

    blackjack_top #(.initial_coin(start_coin), .deck_seed(start_seed)) i_blackjack_top (
        .clk(clk), .reset(reset), .next(next), .hit(hit), .stand(stand), .bet(bet),
        .player_score(player_score), .dealer_score(dealer_score), .coin(coin),
        .player_turn(player_turn), .win(win), .lose(lose), .draw(draw)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // deck lfsr, shift right, mask b400 on a 1 out
    function automatic logic [15:0] deck_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    // low nibble, 0 and 11..15 are tens
    function automatic blackjack_pkg::card_t deck_card(input logic [15:0] s);
        if ((s[3:0] >= 4'd1) && (s[3:0] <= 4'd10)) begin
            return s[3:0];
        end
        return 4'd10;
    endfunction

    function automatic blackjack_pkg::card_t take_card();
        blackjack_pkg::card_t c;
        c = deck_card(model_deck);
        model_deck = deck_step(model_deck);
        return c;
    endfunction

    // one ace may count 11 while the hand stays at 21 or less
    function automatic blackjack_pkg::score_t shown_total(input int hard, input logic ace);
        if (ace && ((hard + 10) <= 21)) begin
            return blackjack_pkg::score_t'(hard + 10);
        end
        return blackjack_pkg::score_t'(hard);
    endfunction

    function automatic blackjack_pkg::outcome_t expected_outcome(
        input blackjack_pkg::score_t p, input blackjack_pkg::score_t d);
        if (p > blackjack_pkg::blackjack_total) begin
            return blackjack_pkg::oc_lose;
        end
        if ((d > blackjack_pkg::blackjack_total) || (p > d)) begin
            return (p == blackjack_pkg::blackjack_total) ? blackjack_pkg::oc_win21
                                                         : blackjack_pkg::oc_win;
        end
        if (p < d) begin
            return blackjack_pkg::oc_lose;
        end
        return blackjack_pkg::oc_draw;
    endfunction

    function automatic int payout(input blackjack_pkg::outcome_t oc,
                                  input blackjack_pkg::bet_t b);
        case (oc)
            blackjack_pkg::oc_win21: return 4 * int'(b);
            blackjack_pkg::oc_win:   return 2 * int'(b);
            blackjack_pkg::oc_draw:  return int'(b);
            default:                 return 0;
        endcase
    endfunction

    // galois lfsr for extra rows, one step per bit
    function automatic logic take_rand_bit();
        logic b;
        b = rand_state[0];
        if (rand_state[0]) begin
            rand_state = (rand_state >> 1) ^ 32'h80200003;
        end else begin
            rand_state = rand_state >> 1;
        end
        return b;
    endfunction

    task automatic add_card(input logic to_player, input blackjack_pkg::card_t c);
        if (to_player) begin
            p_hard = p_hard + int'(c);
            p_ace  = p_ace || (c == 4'd1);
        end else begin
            d_hard = d_hard + int'(c);
            d_ace  = d_ace || (c == 4'd1);
        end
    endtask

    // ----------------------------------------
    // checks
    // ----------------------------------------
    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_score(input string name, input blackjack_pkg::score_t exp,
                               input blackjack_pkg::score_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_coin(input string name, input blackjack_pkg::coin_t exp,
                              input blackjack_pkg::coin_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // win covers both win and win21
    task automatic check_outcome(input string name, input blackjack_pkg::outcome_t exp);
        logic [2:0] exp_flags;
        logic [2:0] act_flags;
        exp_flags[2] = (exp == blackjack_pkg::oc_win) || (exp == blackjack_pkg::oc_win21);
        exp_flags[1] = (exp == blackjack_pkg::oc_lose);
        exp_flags[0] = (exp == blackjack_pkg::oc_draw);
        act_flags    = {win, lose, draw};
        if (act_flags !== exp_flags) begin
            $display("[FAIL] %s expected win/lose/draw %b actual %b", name, exp_flags,
                     act_flags);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // stimulus, set on a falling edge and
    // released on the next one
    // ----------------------------------------
    task automatic press_next(input blackjack_pkg::bet_t b);
        bet  = b;
        next = 1'b1;
        @(negedge clk);
        next = 1'b0;
    endtask

    task automatic press_hit();
        hit = 1'b1;
        @(negedge clk);
        hit = 1'b0;
    endtask

    task automatic press_stand();
        stand = 1'b1;
        @(negedge clk);
        stand = 1'b0;
    endtask

    task automatic build_table();
        logic [1:0] r;
        for (int i = 0; i < table_rows; i++) begin
            row_bet[i]  = fixed_bet[i];
            row_hits[i] = fixed_hits[i];
            row_bad[i]  = fixed_bad[i];
        end
        // bets 1..4 keep the sum of all bets under the start purse
        for (int i = table_rows; i < total_rows; i++) begin
            r[1]        = take_rand_bit();
            r[0]        = take_rand_bit();
            row_bet[i]  = blackjack_pkg::bet_t'(r) + 4'd1;
            r[1]        = take_rand_bit();
            r[0]        = take_rand_bit();
            row_hits[i] = int'(r);
            row_bad[i]  = take_rand_bit();
        end
    endtask

    // ----------------------------------------
    // one round, betting back to betting
    // ----------------------------------------
    task automatic play_round(input int idx);
        blackjack_pkg::bet_t     bad_bet;
        blackjack_pkg::outcome_t exp_oc;
        int                      hits_left;
        int                      waited;
        int                      sum;
        string                   tag;

        tag = $sformatf("row %0d", idx);
        if (row_bad[idx]) begin
            // zero, or one above the purse once it is small enough
            bad_bet = (model_coin < 8'd15) ? blackjack_pkg::bet_t'(model_coin + 8'd1) : 4'd0;
            press_next(bad_bet);
            // an accepted bet would have reached the player turn by now
            repeat (blackjack_pkg::deal_cards) @(negedge clk);
            check_coin({tag, " refused bet coin"}, model_coin, coin);
            check_flag({tag, " refused bet player_turn"}, 1'b0, player_turn);
        end

        press_next(row_bet[idx]);
        bet        = 4'd0;
        model_coin = model_coin - blackjack_pkg::coin_t'(row_bet[idx]);
        p_hard     = 0;
        p_ace      = 1'b0;
        d_hard     = 0;
        d_ace      = 1'b0;
        // player, dealer, player, dealer
        for (int k = 0; k < blackjack_pkg::deal_cards; k++) begin
            add_card((k % 2) == 0, take_card());
        end
        repeat (blackjack_pkg::deal_cards) @(negedge clk);
        check_score({tag, " deal player_score"}, shown_total(p_hard, p_ace), player_score);
        check_score({tag, " deal dealer_score"}, shown_total(d_hard, d_ace), dealer_score);
        check_flag({tag, " deal player_turn"}, 1'b1, player_turn);
        check_coin({tag, " debit coin"}, model_coin, coin);

        // hits stop at 21 or on a bust
        hits_left = row_hits[idx];
        while ((hits_left > 0) &&
               (shown_total(p_hard, p_ace) < blackjack_pkg::blackjack_total)) begin
            press_hit();
            add_card(1'b1, take_card());
            check_score({tag, " hit player_score"}, shown_total(p_hard, p_ace), player_score);
            hits_left--;
        end
        if (shown_total(p_hard, p_ace) < blackjack_pkg::blackjack_total) begin
            press_stand();
        end

        // dealer only draws when the player did not bust
        if (shown_total(p_hard, p_ace) <= blackjack_pkg::blackjack_total) begin
            while (shown_total(d_hard, d_ace) < blackjack_pkg::dealer_stand_total) begin
                add_card(1'b0, take_card());
            end
        end

        waited = 0;
        while (!(win || lose || draw)) begin
            if (waited == flag_wait_limit) begin
                $display("%s no outcome flag rose within %0d cycles", tag, flag_wait_limit);
                abort_run();
            end
            @(negedge clk);
            waited++;
        end

        exp_oc = expected_outcome(shown_total(p_hard, p_ace), shown_total(d_hard, d_ace));
        check_score({tag, " final dealer_score"}, shown_total(d_hard, d_ace), dealer_score);
        check_outcome({tag, " outcome"}, exp_oc);
        // credit clamps at 255
        sum = int'(model_coin) + payout(exp_oc, row_bet[idx]);
        if (sum > 255) begin
            sum = 255;
        end
        model_coin = blackjack_pkg::coin_t'(sum);
        check_coin({tag, " payout coin"}, model_coin, coin);

        press_next(4'd0);
        check_outcome({tag, " flags after next"}, blackjack_pkg::oc_none);
    endtask

    // ----------------------------------------
    // main sequence and watchdog
    // ----------------------------------------
    initial begin
        next       = 1'b0;
        hit        = 1'b0;
        stand      = 1'b0;
        bet        = '0;
        reset      = 1'b1;
        model_deck = start_seed;
        model_coin = start_coin;
        rand_state = 32'hb867;
        p_hard     = 0;
        p_ace      = 1'b0;
        d_hard     = 0;
        d_ace      = 1'b0;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_coin("reset coin", start_coin, coin);
        check_score("reset player_score", 6'd0, player_score);
        check_score("reset dealer_score", 6'd0, dealer_score);
        check_flag("reset player_turn", 1'b0, player_turn);
        check_outcome("reset flags", blackjack_pkg::oc_none);

        for (int i = 0; i < total_rows; i++) begin
            play_round(i);
        end
        $display("Finished with no errors");
        $finish;
    end

    initial begin
        repeat (total_rows * cycles_per_row) @(posedge clk);
        $display("watchdog expired after %0d cycles, the rounds did not finish",
                 total_rows * cycles_per_row);
        abort_run();
    end

endmodule

// File: blackjack_top.f
hw/blackjack_pkg.sv
hw/deck_lfsr.sv
hw/bet_purse.sv
hw/hand_score.sv
hw/game_fsm.sv
hw/hand_settle.sv
hw/blackjack_top.sv
dv/blackjack_chk.sv
dv/blackjack_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the blackjack testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f blackjack_top.f --top-module blackjack_tb \
    -o blackjack_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/blackjack_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" "$log"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
